//--- verilog/sdram_map_pkg.sv
// SDRAM memory map for the slot multiplexer
// Slot identifiers, region offsets, per-slot data widths and refresh period

package sdram_map_pkg;

    // Client count, must stay a power of two for the round-robin wrap
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_IDW  = 2;

    typedef enum logic [SLOT_IDW-1:0] {
        SLOT_MAIN_ROM = 2'd0,
        SLOT_MAIN_RAM = 2'd1,
        SLOT_GFX      = 2'd2,
        SLOT_SOUND    = 2'd3
    } slot_id_e;

    // SDRAM word address and client address port widths
    localparam int SDRAM_AW = 22;
    localparam int SLOT_AW  = 22;

    // Region bases as 16-bit word addresses
    localparam logic [SDRAM_AW-1:0] MAIN_ROM_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET    = 22'h08_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET      = 22'h0A_8000;
    localparam logic [SDRAM_AW-1:0] MAIN_RAM_OFFSET = 22'h3A_8000;

    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W32 = 2'd2
    } width_e;

    // Data width of each client, indexed by slot_id_e
    localparam width_e SLOT_WIDTH [NUM_SLOTS] = '{W16, W16, W32, W8};

    // Clock cycles between refresh slots
    localparam int REFRESH_CW = 7;
    localparam logic [REFRESH_CW-1:0] REFRESH_CYCLES = 7'd64;

endpackage

//--- verilog/sdram_bus_pkg.sv
// Bus types between clients, multiplexer and SDRAM controller
// Request, response and command structs, lane select, sequencer states

package sdram_bus_pkg;

    // Data widths on the controller side
    localparam int WR_DW  = 16;
    localparam int RD_DW  = 32;
    localparam int MASK_W = 2;

    // One client request, held steady until ok
    // wrmask bit high leaves that byte of the word unchanged
    typedef struct packed {
        logic                               cs;
        logic                               wr;
        logic [sdram_map_pkg::SLOT_AW-1:0]  addr;
        logic [WR_DW-1:0]                   din;
        logic [MASK_W-1:0]                  wrmask;
    } slot_req_t;

    // One client response, dout valid while ok is high
    typedef struct packed {
        logic             ok;
        logic [RD_DW-1:0] dout;
    } slot_rsp_t;

    // Command fields presented with sdram_req
    typedef struct packed {
        logic [sdram_map_pkg::SDRAM_AW-1:0] addr;
        logic                               rnw;
        logic [WR_DW-1:0]                   data_write;
        logic [MASK_W-1:0]                  wrmask;
    } sdram_cmd_t;

    // Read lane: width and byte select within the low word
    typedef struct packed {
        sdram_map_pkg::width_e width;
        logic                  sel;
    } lane_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_GRANT   = 3'd1,
        ST_REQ     = 3'd2,
        ST_DATA    = 3'd3,
        ST_DONE    = 3'd4,
        ST_REFRESH = 3'd5
    } seq_state_e;

endpackage

//--- verilog/slot_addr_map.sv
// Client address to SDRAM word address conversion
// Registers the controller command and read lane for the granted slot
`timescale 1ns/1ns

module slot_addr_map (
    input  logic                        clk,
    input  sdram_bus_pkg::slot_req_t    req,
    input  sdram_map_pkg::slot_id_e     grant_id,
    input  logic                        load,
    output sdram_bus_pkg::sdram_cmd_t   cmd,
    output sdram_bus_pkg::lane_t        lane
);

    sdram_map_pkg::width_e                  width;
    logic [sdram_map_pkg::SDRAM_AW-1:0]     offset;
    logic [sdram_map_pkg::SDRAM_AW-1:0]     word_addr;
    logic [sdram_bus_pkg::MASK_W-1:0]       byte_mask;

    always_comb begin
        width = sdram_map_pkg::SLOT_WIDTH[grant_id];
        case (grant_id)
            sdram_map_pkg::SLOT_MAIN_ROM: offset = sdram_map_pkg::MAIN_ROM_OFFSET;
            sdram_map_pkg::SLOT_MAIN_RAM: offset = sdram_map_pkg::MAIN_RAM_OFFSET;
            sdram_map_pkg::SLOT_GFX:      offset = sdram_map_pkg::GFX_OFFSET;
            default:                      offset = sdram_map_pkg::SOUND_OFFSET;
        endcase
        // 32-bit clients step two SDRAM words per address
        case (width)
            sdram_map_pkg::W32: word_addr = {req.addr[sdram_map_pkg::SLOT_AW-2:0], 1'b0};
            sdram_map_pkg::W16: word_addr = req.addr;
            default:            word_addr = {1'b0, req.addr[sdram_map_pkg::SLOT_AW-1:1]};
        endcase
        // Byte clients write one half of the word, the other half masked
        byte_mask = req.addr[0] ? 2'b01 : 2'b10;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cmd.addr <= word_addr + offset;
            cmd.rnw  <= ~req.wr;
            if (width == sdram_map_pkg::W8) begin
                cmd.data_write <= {2{req.din[7:0]}};
                cmd.wrmask     <= byte_mask;
            end else begin
                cmd.data_write <= req.din;
                cmd.wrmask     <= req.wrmask;
            end
            lane.width <= width;
            lane.sel   <= req.addr[0];
        end
    end

endmodule

//--- verilog/slot_arbiter.sv
// Round-robin arbiter over the client chip-selects
// Priority pointer moves past each served client
`timescale 1ns/1ns

module slot_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [sdram_map_pkg::NUM_SLOTS-1:0] slot_cs,
    input  logic                                grant_take,
    output logic                                grant_valid,
    output sdram_map_pkg::slot_id_e             grant_id
);

    logic [sdram_map_pkg::SLOT_IDW-1:0] ptr_q;
    logic [sdram_map_pkg::SLOT_IDW-1:0] idx;
    logic [sdram_map_pkg::SLOT_IDW-1:0] grant_idx;

    // Search from the pointer upwards, wrapping at NUM_SLOTS.
    // The loop runs backwards so the nearest pending slot wins.
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = ptr_q;
        idx         = ptr_q;
        for (int k = sdram_map_pkg::NUM_SLOTS - 1; k >= 0; k--) begin
            idx = ptr_q + sdram_map_pkg::SLOT_IDW'(k);
            if (slot_cs[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    assign grant_id = sdram_map_pkg::slot_id_e'(grant_idx);

    // Served client goes to the back of the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (grant_take) begin
            ptr_q <= grant_idx + 1'b1;
        end
    end

endmodule

//--- verilog/sdram_seq_fsm.sv
// Transaction sequencer towards the SDRAM controller
// Grant, request, acknowledge, data and refresh phases
`timescale 1ns/1ns

module sdram_seq_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  logic                        grant_valid,
    input  sdram_map_pkg::slot_id_e     grant_id,
    output logic                        grant_take,
    input  logic                        refresh_due,
    output logic                        refresh_done,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    output logic                        sdram_req,
    output logic                        refresh_en,
    output logic                        load,
    output logic                        capture,
    output sdram_map_pkg::slot_id_e     owner_id
);

    sdram_bus_pkg::seq_state_e state_q;
    sdram_bus_pkg::seq_state_e state_d;

    always_comb begin
        state_d      = state_q;
        grant_take   = 1'b0;
        refresh_done = 1'b0;
        case (state_q)
            sdram_bus_pkg::ST_IDLE: begin
                // Nothing new starts during a ROM download
                if (!downloading) begin
                    if (refresh_due) begin
                        state_d = sdram_bus_pkg::ST_REFRESH;
                    end else if (grant_valid) begin
                        grant_take = 1'b1;
                        state_d    = sdram_bus_pkg::ST_GRANT;
                    end
                end
            end
            sdram_bus_pkg::ST_GRANT: state_d = sdram_bus_pkg::ST_REQ;
            sdram_bus_pkg::ST_REQ: begin
                if (sdram_ack) begin
                    state_d = sdram_bus_pkg::ST_DATA;
                end
            end
            sdram_bus_pkg::ST_DATA: begin
                if (data_rdy) begin
                    state_d = sdram_bus_pkg::ST_DONE;
                end
            end
            sdram_bus_pkg::ST_DONE: state_d = sdram_bus_pkg::ST_IDLE;
            sdram_bus_pkg::ST_REFRESH: begin
                // Download starting here skips the slot, timer stays due
                refresh_done = !downloading;
                state_d      = sdram_bus_pkg::ST_IDLE;
            end
            default: state_d = sdram_bus_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= sdram_bus_pkg::ST_IDLE;
            owner_id <= sdram_map_pkg::SLOT_MAIN_ROM;
        end else begin
            state_q <= state_d;
            if (grant_take) begin
                owner_id <= grant_id;
            end
        end
    end

    // Command is registered while the arbiter still points at the owner
    assign load       = grant_take;
    assign sdram_req  = (state_q == sdram_bus_pkg::ST_REQ);
    assign capture    = (state_q == sdram_bus_pkg::ST_DONE);
    // Refresh slot and timer reload coincide
    assign refresh_en = refresh_done;

endmodule

//--- verilog/refresh_timer.sv
// Refresh interval counter
// Flags a due refresh and reloads once it is served
`timescale 1ns/1ns

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_done,
    output logic refresh_due
);

    logic [sdram_map_pkg::REFRESH_CW-1:0] count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= sdram_map_pkg::REFRESH_CYCLES;
        end else if (refresh_done) begin
            count_q <= sdram_map_pkg::REFRESH_CYCLES;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Stays high at zero until the sequencer serves it
    assign refresh_due = (count_q == '0);

endmodule

//--- verilog/slot_data_latch.sv
// Read data capture and per-client response generation
// Lane extraction, held dout per client and one-cycle ok
`timescale 1ns/1ns

module slot_data_latch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                data_rdy,
    input  logic [sdram_bus_pkg::RD_DW-1:0]     data_read,
    input  sdram_bus_pkg::lane_t                lane,
    input  sdram_map_pkg::slot_id_e             owner_id,
    input  logic                                capture,
    output sdram_bus_pkg::slot_rsp_t            slot_rsp [sdram_map_pkg::NUM_SLOTS]
);

    logic [sdram_bus_pkg::RD_DW-1:0] word_q;
    logic [sdram_bus_pkg::RD_DW-1:0] lane_data;
    logic [sdram_bus_pkg::RD_DW-1:0] dout_q [sdram_map_pkg::NUM_SLOTS];

    // Word from the controller, also taken on write completion
    always_ff @(posedge clk) begin
        if (data_rdy) begin
            word_q <= data_read;
        end
    end

    // Zero-extended lane, byte select picks the upper byte when set
    always_comb begin
        case (lane.width)
            sdram_map_pkg::W32: lane_data = word_q;
            sdram_map_pkg::W16: lane_data = {16'd0, word_q[15:0]};
            default:            lane_data = {24'd0, lane.sel ? word_q[15:8] : word_q[7:0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
                dout_q[i] <= '0;
            end
        end else if (capture) begin
            dout_q[owner_id] <= lane_data;
        end
    end

    // New value shows during ok, then the register holds it
    always_comb begin
        for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
            slot_rsp[i].ok   = capture && (owner_id == sdram_map_pkg::slot_id_e'(i));
            slot_rsp[i].dout = slot_rsp[i].ok ? lane_data : dout_q[i];
        end
    end

endmodule

//--- verilog/sdram_slot_mux.sv
// SDRAM slot multiplexer top level
// Arbiter, address map, sequencer, refresh timer and data latch
`timescale 1ns/1ns

module sdram_slot_mux (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            downloading,
    input  sdram_bus_pkg::slot_req_t        slot_req [sdram_map_pkg::NUM_SLOTS],
    output sdram_bus_pkg::slot_rsp_t        slot_rsp [sdram_map_pkg::NUM_SLOTS],
    output logic                            sdram_req,
    output sdram_bus_pkg::sdram_cmd_t       sdram_cmd,
    input  logic                            sdram_ack,
    input  logic                            data_rdy,
    input  logic [sdram_bus_pkg::RD_DW-1:0] data_read,
    output logic                            refresh_en
);

    logic [sdram_map_pkg::NUM_SLOTS-1:0] slot_cs;
    logic                                grant_valid;
    logic                                grant_take;
    sdram_map_pkg::slot_id_e             grant_id;
    sdram_map_pkg::slot_id_e             owner_id;
    sdram_bus_pkg::slot_req_t            grant_req;
    sdram_bus_pkg::lane_t                lane;
    logic                                refresh_due;
    logic                                refresh_done;
    logic                                load;
    logic                                capture;

    for (genvar i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin : g_cs
        assign slot_cs[i] = slot_req[i].cs;
    end

    assign grant_req = slot_req[grant_id];

    slot_arbiter u_arbiter (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .slot_cs     ( slot_cs      ),
        .grant_take  ( grant_take   ),
        .grant_valid ( grant_valid  ),
        .grant_id    ( grant_id     )
    );

    slot_addr_map u_addr_map (
        .clk         ( clk          ),
        .req         ( grant_req    ),
        .grant_id    ( grant_id     ),
        .load        ( load         ),
        .cmd         ( sdram_cmd    ),
        .lane        ( lane         )
    );

    sdram_seq_fsm u_seq (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .downloading  ( downloading  ),
        .grant_valid  ( grant_valid  ),
        .grant_id     ( grant_id     ),
        .grant_take   ( grant_take   ),
        .refresh_due  ( refresh_due  ),
        .refresh_done ( refresh_done ),
        .sdram_ack    ( sdram_ack    ),
        .data_rdy     ( data_rdy     ),
        .sdram_req    ( sdram_req    ),
        .refresh_en   ( refresh_en   ),
        .load         ( load         ),
        .capture      ( capture      ),
        .owner_id     ( owner_id     )
    );

    refresh_timer u_refresh (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .refresh_done ( refresh_done ),
        .refresh_due  ( refresh_due  )
    );

    slot_data_latch u_latch (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .data_rdy  ( data_rdy  ),
        .data_read ( data_read ),
        .lane      ( lane      ),
        .owner_id  ( owner_id  ),
        .capture   ( capture   ),
        .slot_rsp  ( slot_rsp  )
    );

endmodule

//--- dv/sdram_slot_mux_checker.sv
// Concurrent assertions for the SDRAM slot multiplexer
// Controller handshake, refresh slot and client ok rules
`timescale 1ns/1ns

module sdram_slot_mux_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     downloading,
    input logic                     sdram_req,
    input logic                     sdram_ack,
    input logic                     refresh_en,
    input sdram_bus_pkg::slot_rsp_t slot_rsp [sdram_map_pkg::NUM_SLOTS]
);

    int   fail_count = 0;
    logic ok_any;
    logic busy_q;

    always_comb begin
        ok_any = 1'b0;
        for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
            ok_any = ok_any | slot_rsp[i].ok;
        end
    end

    // Transaction open from its request until its ok
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (ok_any) begin
            busy_q <= 1'b0;
        end else if (sdram_req) begin
            busy_q <= 1'b1;
        end
    end

    // Request held until the controller acknowledges, then dropped
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            $error("sdram_req fell before sdram_ack");
            fail_count++;
        end

    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        sdram_req && sdram_ack |=> !sdram_req)
        else begin
            $error("sdram_req still high after sdram_ack");
            fail_count++;
        end

    a_refresh_idle: assert property (@(posedge clk) disable iff (rst)
        !(refresh_en && (sdram_req || busy_q)))
        else begin
            $error("refresh_en during a transaction");
            fail_count++;
        end

    // No refresh slot starts during a ROM download
    a_refresh_dl: assert property (@(posedge clk) disable iff (rst)
        downloading |=> !refresh_en)
        else begin
            $error("refresh_en while downloading");
            fail_count++;
        end

    for (genvar i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin : g_ok
        a_ok_pulse: assert property (@(posedge clk) disable iff (rst)
            slot_rsp[i].ok |=> !slot_rsp[i].ok)
            else begin
                $error("ok high for two cycles on slot %0d", i);
                fail_count++;
            end
    end

endmodule

bind sdram_slot_mux sdram_slot_mux_checker u_checker (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .refresh_en  ( refresh_en  ),
    .slot_rsp    ( slot_rsp    )
);

//--- dv/sdram_slot_mux_tb.sv
// Testbench for the SDRAM slot multiplexer
// Clock, reset, SDRAM model, stimulus file reader, checks and watchdog
`timescale 1ns/1ns

module sdram_slot_mux_tb;

    localparam int REC_W     = 7;
    localparam int MAX_REC   = 32;
    localparam int TXN_MAX   = 16;
    localparam int HOLD_CYC  = 100;

    logic                            clk;
    logic                            rst;
    logic                            downloading;
    sdram_bus_pkg::slot_req_t        slot_req [sdram_map_pkg::NUM_SLOTS];
    sdram_bus_pkg::slot_rsp_t        slot_rsp [sdram_map_pkg::NUM_SLOTS];
    logic                            sdram_req;
    sdram_bus_pkg::sdram_cmd_t       sdram_cmd;
    logic                            sdram_ack;
    logic                            data_rdy;
    logic [31:0]                     data_read;
    logic                            refresh_en;

    logic [31:0] stim [0:REC_W*MAX_REC-1];
    logic [15:0] mem [logic [21:0]];
    logic [15:0] ref_mem [logic [21:0]];
    integer      seed;
    int          n_rec;
    int          refresh_gap;
    bit          loaded;

    sdram_slot_mux UUT (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .slot_req    ( slot_req    ),
        .slot_rsp    ( slot_rsp    ),
        .sdram_req   ( sdram_req   ),
        .sdram_cmd   ( sdram_cmd   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .refresh_en  ( refresh_en  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Initial SDRAM contents folded over every address bit
    function automatic logic [15:0] pattern(input logic [21:0] a);
        return a[15:0] ^ {10'd0, a[21:16]} ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] model_word(input logic [21:0] a);
        return mem.exists(a) ? mem[a] : pattern(a);
    endfunction

    function automatic logic [15:0] ref_word(input logic [21:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : pattern(a);
    endfunction

    // Word address from the width rule plus the region base
    function automatic logic [21:0] word_address(input int s, input logic [21:0] a);
        logic [21:0] base;
        base = (s == 0) ? sdram_map_pkg::MAIN_ROM_OFFSET :
               (s == 1) ? sdram_map_pkg::MAIN_RAM_OFFSET :
               (s == 2) ? sdram_map_pkg::GFX_OFFSET : sdram_map_pkg::SOUND_OFFSET;
        case (sdram_map_pkg::SLOT_WIDTH[s])
            sdram_map_pkg::W32: return (a << 1) + base;
            sdram_map_pkg::W16: return a + base;
            default:            return (a >> 1) + base;
        endcase
    endfunction

    function automatic logic [31:0] expected_read(input int s, input logic [21:0] a);
        logic [21:0] wa;
        logic [15:0] w;
        wa = word_address(s, a);
        w  = ref_word(wa);
        case (sdram_map_pkg::SLOT_WIDTH[s])
            sdram_map_pkg::W32: return {ref_word(wa + 1'b1), w};
            sdram_map_pkg::W16: return {16'd0, w};
            default:            return {24'd0, a[0] ? w[15:8] : w[7:0]};
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
            fail_now("Wrong value seen");
        end
    endtask

    // SDRAM controller model with one outstanding request
    initial begin
        int          d;
        logic [15:0] cur;
        logic [21:0] a;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (sdram_req) begin
                d = 1 + ($unsigned($random(seed)) % 4);
                repeat (d - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                a = sdram_cmd.addr;
                if (sdram_cmd.rnw) begin
                    data_read <= {model_word(a + 1'b1), model_word(a)};
                end else begin
                    cur    = model_word(a);
                    mem[a] = {sdram_cmd.wrmask[1] ? cur[15:8] : sdram_cmd.data_write[15:8],
                              sdram_cmd.wrmask[0] ? cur[7:0]  : sdram_cmd.data_write[7:0]};
                    data_read <= '0;
                end
                d = 1 + ($unsigned($random(seed)) % 4);
                repeat (d - 1) @(posedge clk);
                data_rdy <= 1'b1;
                @(posedge clk);
                data_rdy <= 1'b0;
            end
        end
    end

    // Refresh spacing while traffic is allowed
    always @(posedge clk) begin
        if (rst || downloading || refresh_en) begin
            refresh_gap = 0;
        end else begin
            refresh_gap++;
            if (refresh_gap > sdram_map_pkg::REFRESH_CYCLES + TXN_MAX) begin
                fail_now("No refresh slot within the refresh interval");
            end
        end
    end

    // Watch the bound checker
    always @(posedge clk) begin
        if (UUT.u_checker.fail_count != 0) begin
            fail_now("An assertion in the bound checker failed");
        end
    end

    initial begin
        wait (loaded);
        repeat (n_rec * 40 + HOLD_CYC + 400) @(posedge clk);
        fail_now("Timeout waiting for client ok pulses");
    end

    // Runs one group of single, burst (two oks per client) or download-hold accesses
    task automatic run_group(input int first, input int last, input int mode);
        int                        reps;
        int                        s;
        int                        base;
        int                        n_ok [sdram_map_pkg::NUM_SLOTS];
        bit                        active [sdram_map_pkg::NUM_SLOTS];
        bit                        is_read [sdram_map_pkg::NUM_SLOTS];
        logic [31:0]               exp [sdram_map_pkg::NUM_SLOTS];
        logic [21:0]               wa;
        logic [15:0]               cur;
        sdram_bus_pkg::slot_req_t  r;
        bit                        done;
        reps = (mode == 1) ? 2 : 1;
        for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
            n_ok[i]   = 0;
            active[i] = 1'b0;
        end
        @(posedge clk);
        if (mode == 2) begin
            downloading <= 1'b1;
        end
        for (int k = first; k < last; k++) begin
            base      = k * REC_W;
            s         = stim[base];
            r.cs      = 1'b1;
            r.wr      = stim[base+1][0];
            r.addr    = stim[base+2][21:0];
            r.din     = stim[base+3][15:0];
            r.wrmask  = stim[base+4][1:0];
            is_read[s] = !r.wr;
            if (r.wr) begin
                wa          = word_address(s, r.addr);
                cur         = ref_word(wa);
                ref_mem[wa] = {r.wrmask[1] ? cur[15:8] : r.din[15:8],
                               r.wrmask[0] ? cur[7:0]  : r.din[7:0]};
            end else begin
                exp[s] = expected_read(s, r.addr);
                check_eq("stim expected dout", stim[base+5], exp[s]);
            end
            active[s]   = 1'b1;
            slot_req[s] <= r;
        end
        if (mode == 2) begin
            repeat (HOLD_CYC) begin
                @(posedge clk);
                check_eq("sdram_req", sdram_req, 1'b0);
                check_eq("refresh_en", refresh_en, 1'b0);
                for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
                    check_eq($sformatf("slot_rsp[%0d].ok", i), slot_rsp[i].ok, 1'b0);
                end
            end
            downloading <= 1'b0;
        end
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
                if (slot_rsp[i].ok) begin
                    if (!active[i]) begin
                        fail_now($sformatf("Client %0d got ok without a request", i));
                    end
                    n_ok[i]++;
                    if (is_read[i]) begin
                        check_eq($sformatf("slot_rsp[%0d].dout", i), slot_rsp[i].dout, exp[i]);
                    end
                    for (int t = 0; t < sdram_map_pkg::NUM_SLOTS; t++) begin
                        if (n_ok[i] > 1 && active[t] && n_ok[t] == 0) begin
                            fail_now($sformatf("Client %0d served twice before %0d", i, t));
                        end
                    end
                    if (n_ok[i] == reps) begin
                        slot_req[i].cs <= 1'b0;
                        active[i] = 1'b0;
                    end
                end
            end
            done = 1'b1;
            for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
                if (active[i]) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    initial begin
        int idx;
        int last;
        int mode;
        rst          = 1'b1;
        downloading  = 1'b0;
        refresh_gap  = 0;
        loaded       = 1'b0;
        seed         = 32'h16cd;
        for (int i = 0; i < sdram_map_pkg::NUM_SLOTS; i++) begin
            slot_req[i] = '0;
        end
        for (int i = 0; i < REC_W * MAX_REC; i++) begin
            stim[i] = '1;
        end
        $readmemh("dv/slot_stim.txt", stim);
        n_rec = 0;
        while (n_rec < MAX_REC && stim[n_rec*REC_W] !== 32'hffff_ffff) begin
            n_rec++;
        end
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idx = 0;
        while (idx < n_rec) begin
            mode = stim[idx*REC_W+6];
            last = idx + 1;
            while (mode != 0 && last < n_rec && stim[last*REC_W+6] == mode) begin
                last++;
            end
            run_group(idx, last, mode);
            idx = last;
        end
        repeat (20) @(posedge clk);
        if (UUT.u_checker.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- dv/slot_stim.txt
// slot wr addr din wrmask expected_dout mode
// mode 0 single access, 1 all-slots burst, 2 download hold
0 0 000010 0000 0 00005a4a 0
0 0 001234 0000 0 0000486e 0
2 0 000100 0000 0 d851d850 0
2 0 000777 0000 0 d4bfd4be 0
3 0 000021 0000 0 0000005a 0
3 0 000020 0000 0 00000042 0
3 0 0003ff 0000 0 0000005b 0
1 0 000004 0000 0 0000da64 0
1 1 000004 1122 0 00000000 0
1 0 000004 0000 0 00001122 0
1 1 000004 3344 1 00000000 0
1 0 000004 0000 0 00003322 0
1 1 000004 5566 2 00000000 0
1 0 000004 0000 0 00003366 0
1 1 000004 7788 3 00000000 0
1 0 000004 0000 0 00003366 0
0 0 000010 0000 0 00005a4a 1
1 0 000004 0000 0 00003366 1
2 0 000100 0000 0 d851d850 1
3 0 000020 0000 0 00000042 1
0 0 001234 0000 0 0000486e 2
2 0 000777 0000 0 d4bfd4be 2
3 0 0003ff 0000 0 0000005b 2
1 0 000004 0000 0 00003366 2

//--- files.f
verilog/sdram_map_pkg.sv
verilog/sdram_bus_pkg.sv
verilog/slot_addr_map.sv
verilog/slot_arbiter.sv
verilog/sdram_seq_fsm.sv
verilog/refresh_timer.sv
verilog/slot_data_latch.sv
verilog/sdram_slot_mux.sv
dv/sdram_slot_mux_checker.sv
dv/sdram_slot_mux_tb.sv
